// ==== logic/exec_settings.svh ====
/* Execute stage settings */

`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath widths
`define EXEC_XLEN 64
`define EXEC_RIDX_W 5

// machine csr addresses
`define EXEC_CSR_MTVEC 12'h305
`define EXEC_CSR_MSCRATCH 12'h340
`define EXEC_CSR_MEPC 12'h341
`define EXEC_CSR_MCAUSE 12'h342

// trap vector after reset
`define EXEC_MTVEC_RESET 64'h0000_0000_8000_1000

// environment call from m-mode
`define EXEC_CAUSE_ECALL 64'd11

`endif

// ==== logic/exec_pkg.sv ====
/* Execute stage types */

`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt,
    op_beq,
    op_bne,
    op_jal,
    op_csrrw,
    op_csrrs,
    op_ecall
  } exec_opcode_e;

  typedef enum logic [2:0] {
    exc_idle,
    exc_save_epc,
    exc_save_cause,
    exc_load_vec,
    exc_done
  } exc_state_e;

  // decoded instruction as handed over by decode
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]   pc;
    logic [31:0]             inst;
    exec_opcode_e            opcode;
    logic [`EXEC_XLEN-1:0]   op1;
    logic [`EXEC_XLEN-1:0]   op2;
    logic [`EXEC_XLEN-1:0]   op3;
    logic [`EXEC_RIDX_W-1:0] rd;
    logic                    rd_wen;
  } exec_req_t;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0]   pc;
    logic [31:0]             inst;
    logic [`EXEC_RIDX_W-1:0] rd;
    logic                    rd_wen;
    logic [`EXEC_XLEN-1:0]   rd_wdata;
    logic                    pc_jmp;
    logic [`EXEC_XLEN-1:0]   pc_jmpaddr;
  } exec_result_t;

  typedef struct packed {
    logic [11:0]           addr;
    logic                  ren;
    logic                  wen;
    logic [`EXEC_XLEN-1:0] wdata;
  } csr_req_t;

endpackage

`default_nettype wire

// ==== logic/exe_unit.sv ====
/* Single-cycle execution unit */

`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exe_unit (
  input  exec_pkg::exec_req_t    i_req,
  input  logic                   i_commit,
  input  logic [`EXEC_XLEN-1:0]  i_csr_rdata,
  output exec_pkg::csr_req_t     o_csr,
  output logic [`EXEC_XLEN-1:0]  o_rd_wdata,
  output logic                   o_pc_jmp,
  output logic [`EXEC_XLEN-1:0]  o_pc_jmpaddr
);

  import exec_pkg::*;

  localparam logic [`EXEC_XLEN-1:0] inst_bytes = 4;

  logic [5:0] shamt;
  logic       slt;
  logic       is_csr;

  assign shamt  = i_req.op2[5:0];
  assign slt    = $signed(i_req.op1) < $signed(i_req.op2);
  assign is_csr = (i_req.opcode == op_csrrw) || (i_req.opcode == op_csrrs);

  always_comb begin
    o_rd_wdata   = '0;
    o_pc_jmp     = 1'b0;
    o_pc_jmpaddr = '0;
    case (i_req.opcode)
      op_add: o_rd_wdata = i_req.op1 + i_req.op2;
      op_sub: o_rd_wdata = i_req.op1 - i_req.op2;
      op_and: o_rd_wdata = i_req.op1 & i_req.op2;
      op_or:  o_rd_wdata = i_req.op1 | i_req.op2;
      op_xor: o_rd_wdata = i_req.op1 ^ i_req.op2;
      op_sll: o_rd_wdata = i_req.op1 << shamt;
      op_srl: o_rd_wdata = i_req.op1 >> shamt;
      op_slt: o_rd_wdata = {{(`EXEC_XLEN-1){1'b0}}, slt};
      op_beq: o_pc_jmp = (i_req.op1 == i_req.op2);
      op_bne: o_pc_jmp = (i_req.op1 != i_req.op2);
      op_jal: begin
        // link to the next sequential instruction
        o_pc_jmp   = 1'b1;
        o_rd_wdata = i_req.pc + inst_bytes;
      end
      // rd gets the value before the write
      op_csrrw, op_csrrs: o_rd_wdata = i_csr_rdata;
      default: ;
    endcase

    // target comes precomputed from decode
    if (o_pc_jmp) begin
      o_pc_jmpaddr = i_req.op3;
    end
  end

  always_comb begin
    o_csr = '0;
    if (is_csr) begin
      o_csr.addr = i_req.op2[11:0];
      o_csr.ren  = 1'b1;
      // write lands only on the result handshake
      o_csr.wen  = i_commit;
      if (i_req.opcode == op_csrrs) begin
        o_csr.wdata = i_csr_rdata | i_req.op1;
      end else begin
        o_csr.wdata = i_req.op1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/exception_unit.sv ====
/* Ecall exception sequencer */

`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exception_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_start,
  input  logic [`EXEC_XLEN-1:0]  i_pc,
  input  logic                   i_ack,
  input  logic [`EXEC_XLEN-1:0]  i_csr_rdata,
  output logic                   o_done,
  output exec_pkg::csr_req_t     o_csr,
  output logic [`EXEC_XLEN-1:0]  o_pc_jmpaddr
);

  import exec_pkg::*;

  exc_state_e            state;
  exc_state_e            state_next;
  logic [`EXEC_XLEN-1:0] vec_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= exc_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      exc_idle:       if (i_start) state_next = exc_save_epc;
      exc_save_epc:   state_next = exc_save_cause;
      exc_save_cause: state_next = exc_load_vec;
      exc_load_vec:   state_next = exc_done;
      exc_done:       if (i_ack) state_next = exc_idle;
      default:        state_next = exc_idle;
    endcase
  end

  // one csr access per step
  always_comb begin
    o_csr = '0;
    case (state)
      exc_save_epc: begin
        o_csr.addr  = `EXEC_CSR_MEPC;
        o_csr.wen   = 1'b1;
        o_csr.wdata = i_pc;
      end
      exc_save_cause: begin
        o_csr.addr  = `EXEC_CSR_MCAUSE;
        o_csr.wen   = 1'b1;
        o_csr.wdata = `EXEC_CAUSE_ECALL;
      end
      exc_load_vec: begin
        o_csr.addr = `EXEC_CSR_MTVEC;
        o_csr.ren  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == exc_load_vec) begin
      vec_q <= i_csr_rdata;
    end
  end

  assign o_pc_jmpaddr = vec_q;
  assign o_done       = (state == exc_done);

  // stage must not restart a sequence in progress
  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    i_start |-> (state == exc_idle));

endmodule

`default_nettype wire

// ==== logic/csr_file.sv ====
/* Machine-mode CSR file */

`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module csr_file (
  input  logic                   clk,
  input  logic                   rst,
  input  exec_pkg::csr_req_t     i_csr,
  output logic [`EXEC_XLEN-1:0]  o_rdata
);

  logic [`EXEC_XLEN-1:0] mtvec;
  logic [`EXEC_XLEN-1:0] mscratch;
  logic [`EXEC_XLEN-1:0] mepc;
  logic [`EXEC_XLEN-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec    <= `EXEC_MTVEC_RESET;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (i_csr.wen) begin
      case (i_csr.addr)
        `EXEC_CSR_MTVEC:    mtvec <= i_csr.wdata;
        `EXEC_CSR_MSCRATCH: mscratch <= i_csr.wdata;
        // epc is always 4-byte aligned
        `EXEC_CSR_MEPC:     mepc <= {i_csr.wdata[`EXEC_XLEN-1:2], 2'b00};
        `EXEC_CSR_MCAUSE:   mcause <= i_csr.wdata;
        default: ;
      endcase
    end
  end

  // unknown addresses read as zero
  always_comb begin
    o_rdata = '0;
    if (i_csr.ren) begin
      case (i_csr.addr)
        `EXEC_CSR_MTVEC:    o_rdata = mtvec;
        `EXEC_CSR_MSCRATCH: o_rdata = mscratch;
        `EXEC_CSR_MEPC:     o_rdata = mepc;
        `EXEC_CSR_MCAUSE:   o_rdata = mcause;
        default:            o_rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/exe_stage.sv ====
/* Execute stage controller */

`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exe_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_decoded_req,
  input  exec_pkg::exec_req_t    i_decoded,
  output logic                   o_decoded_ack,
  output logic                   o_executed_req,
  output exec_pkg::exec_result_t o_executed,
  input  logic                   i_executed_ack,
  input  logic [`EXEC_XLEN-1:0]  i_csr_rdata,
  output exec_pkg::csr_req_t     o_csr
);

  import exec_pkg::*;

  logic                  decoded_hs;
  logic                  executed_hs;
  logic                  is_ecall;
  exec_req_t             req_q;
  logic                  unit_req_q;
  logic                  sel_exc;
  logic                  start_q;
  csr_req_t              unit_csr;
  logic [`EXEC_XLEN-1:0] unit_rd_wdata;
  logic                  unit_pc_jmp;
  logic [`EXEC_XLEN-1:0] unit_pc_jmpaddr;
  logic                  exc_done;
  csr_req_t              exc_csr;
  logic [`EXEC_XLEN-1:0] exc_pc_jmpaddr;
  exec_result_t          result;

  assign is_ecall    = (i_decoded.opcode == op_ecall);
  assign decoded_hs  = i_decoded_req & o_decoded_ack;
  assign executed_hs = o_executed_req & i_executed_ack;

  // idle when nothing is in flight
  assign o_decoded_ack  = ~(unit_req_q | sel_exc);
  assign o_executed_req = unit_req_q | (sel_exc & exc_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      unit_req_q <= 1'b0;
      sel_exc    <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      start_q <= decoded_hs & is_ecall;
      if (decoded_hs) begin
        unit_req_q <= ~is_ecall;
        sel_exc    <= is_ecall;
      end else if (executed_hs) begin
        unit_req_q <= 1'b0;
        sel_exc    <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (decoded_hs) begin
      req_q <= i_decoded;
    end
  end

  // ordinary unit owns the csr port while its result is pending
  assign o_csr = unit_req_q ? unit_csr : exc_csr;

  always_comb begin
    result.pc         = req_q.pc;
    result.inst       = req_q.inst;
    result.rd         = req_q.rd;
    result.rd_wen     = sel_exc ? 1'b0 : req_q.rd_wen;
    result.rd_wdata   = sel_exc ? '0 : unit_rd_wdata;
    result.pc_jmp     = sel_exc ? 1'b1 : unit_pc_jmp;
    result.pc_jmpaddr = sel_exc ? exc_pc_jmpaddr : unit_pc_jmpaddr;
  end

  assign o_executed = executed_hs ? result : '0;

  exe_unit u_exe_unit (
    .i_req        (req_q),
    .i_commit     (executed_hs),
    .i_csr_rdata  (i_csr_rdata),
    .o_csr        (unit_csr),
    .o_rd_wdata   (unit_rd_wdata),
    .o_pc_jmp     (unit_pc_jmp),
    .o_pc_jmpaddr (unit_pc_jmpaddr)
  );

  exception_unit u_exception_unit (
    .clk          (clk),
    .rst          (rst),
    .i_start      (start_q),
    .i_pc         (req_q.pc),
    .i_ack        (i_executed_ack),
    .i_csr_rdata  (i_csr_rdata),
    .o_done       (exc_done),
    .o_csr        (exc_csr),
    .o_pc_jmpaddr (exc_pc_jmpaddr)
  );

  a_req_held: assert property (@(posedge clk) disable iff (rst)
    o_executed_req && !i_executed_ack |=> o_executed_req);

  a_one_side: assert property (@(posedge clk) disable iff (rst)
    !(o_decoded_ack && o_executed_req));

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
/* Execute stage top */

`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exec_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_decoded_req,
  input  exec_pkg::exec_req_t    i_decoded,
  output logic                   o_decoded_ack,
  output logic                   o_executed_req,
  output exec_pkg::exec_result_t o_executed,
  input  logic                   i_executed_ack
);

  import exec_pkg::*;

  csr_req_t              csr_req;
  logic [`EXEC_XLEN-1:0] csr_rdata;

  exe_stage u_exe_stage (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (i_decoded_req),
    .i_decoded      (i_decoded),
    .o_decoded_ack  (o_decoded_ack),
    .o_executed_req (o_executed_req),
    .o_executed     (o_executed),
    .i_executed_ack (i_executed_ack),
    .i_csr_rdata    (csr_rdata),
    .o_csr          (csr_req)
  );

  csr_file u_csr_file (
    .clk     (clk),
    .rst     (rst),
    .i_csr   (csr_req),
    .o_rdata (csr_rdata)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
/* Testbench clock and reset */

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;
  end

  // released on a falling edge after three rising edges
  initial begin
    o_rst = 1'b1;
    repeat (3) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_exec_top.sv ====
/* Execute stage testbench */

`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module tb_exec_top;

  import exec_pkg::*;

  localparam int timeout_cycles = 50;

  logic                  clk;
  logic                  rst;
  logic                  decoded_req;
  exec_req_t             decoded;
  logic                  decoded_ack;
  logic                  executed_req;
  exec_result_t          executed;
  logic                  executed_ack;
  logic [63:0]           rng_state;
  logic [`EXEC_XLEN-1:0] m_mtvec;
  logic [`EXEC_XLEN-1:0] m_mscratch;
  logic [`EXEC_XLEN-1:0] m_mepc;
  logic [`EXEC_XLEN-1:0] m_mcause;

  tb_clock_gen u_clock_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  exec_top dut (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (decoded_req),
    .i_decoded      (decoded),
    .o_decoded_ack  (decoded_ack),
    .o_executed_req (executed_req),
    .o_executed     (executed),
    .i_executed_ack (executed_ack)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [255:0] got,
                           input logic [255:0] want);
    assert (got === want) else begin
      stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                  name, got, want));
    end
  endtask

  function automatic logic [63:0] xorshift64();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  function automatic logic [63:0] read_model_csr(input logic [11:0] addr);
    case (addr)
      `EXEC_CSR_MTVEC:    return m_mtvec;
      `EXEC_CSR_MSCRATCH: return m_mscratch;
      `EXEC_CSR_MEPC:     return m_mepc;
      `EXEC_CSR_MCAUSE:   return m_mcause;
      default:            return '0;
    endcase
  endfunction

  function automatic void write_model_csr(input logic [11:0] addr, input logic [63:0] val);
    case (addr)
      `EXEC_CSR_MTVEC:    m_mtvec = val;
      `EXEC_CSR_MSCRATCH: m_mscratch = val;
      `EXEC_CSR_MEPC:     m_mepc = val & ~64'h3;
      `EXEC_CSR_MCAUSE:   m_mcause = val;
      default: ;
    endcase
  endfunction

  // expected result and the matching csr model update
  function automatic exec_result_t model_result(input exec_req_t r);
    exec_result_t e;
    logic [63:0]  old;
    e        = '0;
    e.pc     = r.pc;
    e.inst   = r.inst;
    e.rd     = r.rd;
    e.rd_wen = r.rd_wen;
    case (r.opcode)
      op_add: e.rd_wdata = r.op1 + r.op2;
      op_sub: e.rd_wdata = r.op1 - r.op2;
      op_and: e.rd_wdata = r.op1 & r.op2;
      op_or:  e.rd_wdata = r.op1 | r.op2;
      op_xor: e.rd_wdata = r.op1 ^ r.op2;
      op_sll: e.rd_wdata = r.op1 << r.op2[5:0];
      op_srl: e.rd_wdata = r.op1 >> r.op2[5:0];
      op_slt: e.rd_wdata = {63'd0, $signed(r.op1) < $signed(r.op2)};
      op_beq: e.pc_jmp = (r.op1 == r.op2);
      op_bne: e.pc_jmp = (r.op1 != r.op2);
      op_jal: begin
        e.pc_jmp   = 1'b1;
        e.rd_wdata = r.pc + 64'd4;
      end
      op_csrrw, op_csrrs: begin
        old        = read_model_csr(r.op2[11:0]);
        e.rd_wdata = old;
        write_model_csr(r.op2[11:0], (r.opcode == op_csrrs) ? (old | r.op1) : r.op1);
      end
      op_ecall: begin
        e.rd_wen = 1'b0;
        e.pc_jmp = 1'b1;
        write_model_csr(`EXEC_CSR_MEPC, r.pc);
        write_model_csr(`EXEC_CSR_MCAUSE, `EXEC_CAUSE_ECALL);
      end
      default: ;
    endcase
    if (r.opcode == op_ecall) begin
      e.pc_jmpaddr = m_mtvec;
    end else if (e.pc_jmp) begin
      e.pc_jmpaddr = r.op3;
    end
    return e;
  endfunction

  function automatic exec_req_t build_req(input exec_opcode_e op, input logic [63:0] a,
                                          input logic [63:0] b, input logic [63:0] c);
    exec_req_t   r;
    logic [63:0] x;
    x        = xorshift64();
    r.pc     = xorshift64();
    r.inst   = x[31:0];
    r.rd     = x[36:32];
    r.rd_wen = x[40];
    r.opcode = op;
    r.op1    = a;
    r.op2    = b;
    r.op3    = c;
    return r;
  endfunction

  // called on a falling edge, returns on a falling edge
  task automatic issue(input exec_req_t r, input int hold);
    exec_result_t want;
    exec_result_t got;
    int           waited;
    want        = model_result(r);
    decoded_req = 1'b1;
    decoded     = r;
    waited      = 0;
    while (!decoded_ack) begin
      if (waited == timeout_cycles) begin
        stop_with_failure("timeout waiting for o_decoded_ack");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    @(negedge clk);
    decoded_req = 1'b0;
    decoded     = '0;
    waited      = 0;
    while (!executed_req) begin
      expect_eq("o_decoded_ack", decoded_ack, 0);
      expect_eq("o_executed", executed, 0);
      if (waited == timeout_cycles) begin
        stop_with_failure("timeout waiting for o_executed_req");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    expect_eq("o_executed_req latency", waited, (r.opcode == op_ecall) ? 4 : 0);
    for (int i = 0; i < hold; i++) begin
      expect_eq("o_executed_req", executed_req, 1);
      expect_eq("o_decoded_ack", decoded_ack, 0);
      expect_eq("o_executed", executed, 0);
      @(negedge clk);
    end
    executed_ack = 1'b1;
    #2;
    got = executed;
    @(negedge clk);
    executed_ack = 1'b0;
    expect_eq("o_executed.pc", got.pc, want.pc);
    expect_eq("o_executed.inst", got.inst, want.inst);
    expect_eq("o_executed.rd", got.rd, want.rd);
    expect_eq("o_executed.rd_wen", got.rd_wen, want.rd_wen);
    expect_eq("o_executed.rd_wdata", got.rd_wdata, want.rd_wdata);
    expect_eq("o_executed.pc_jmp", got.pc_jmp, want.pc_jmp);
    expect_eq("o_executed.pc_jmpaddr", got.pc_jmpaddr, want.pc_jmpaddr);
  endtask

  task automatic check_reset_state();
    int waited;
    waited = 0;
    while (rst !== 1'b0) begin
      if (waited == timeout_cycles) begin
        stop_with_failure("timeout waiting for reset release");
      end else begin
        @(posedge clk);
        waited++;
      end
    end
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      expect_eq("o_executed_req", executed_req, 0);
      expect_eq("o_decoded_ack", decoded_ack, 1);
      expect_eq("o_executed", executed, 0);
    end
  endtask

  task automatic alu_sweep();
    exec_req_t r;
    for (int i = 0; i < 40; i++) begin
      r = build_req(exec_opcode_e'(xorshift64() % 64'd8), xorshift64(), xorshift64(), '0);
      issue(r, 0);
    end
  endtask

  task automatic control_flow();
    issue(build_req(op_beq, 64'h55, 64'h55, 64'h8000_0040), 0);
    issue(build_req(op_beq, 64'h55, 64'h56, 64'h8000_0040), 0);
    issue(build_req(op_bne, 64'h77, 64'h77, 64'h8000_0080), 0);
    issue(build_req(op_bne, 64'h77, 64'h78, 64'h8000_0080), 0);
    issue(build_req(op_jal, '0, '0, 64'h8000_0100), 0);
  endtask

  task automatic csr_access();
    issue(build_req(op_csrrw, 64'hdead_beef_0000_1234, `EXEC_CSR_MSCRATCH, '0), 0);
    issue(build_req(op_csrrs, 64'h0f00, `EXEC_CSR_MSCRATCH, '0), 0);
    // unimplemented address
    issue(build_req(op_csrrs, 64'hff, 64'h7c0, '0), 0);
    issue(build_req(op_csrrw, 64'h1111_2222_3333_4444, `EXEC_CSR_MSCRATCH, '0), 0);
    issue(build_req(op_csrrs, '0, `EXEC_CSR_MSCRATCH, '0), 0);
  endtask

  task automatic ecall_trap();
    exec_req_t r;
    r    = build_req(op_ecall, '0, '0, '0);
    r.pc = 64'h0000_0000_8000_0206;
    issue(r, 0);
    issue(build_req(op_csrrs, '0, `EXEC_CSR_MEPC, '0), 0);
    issue(build_req(op_csrrs, '0, `EXEC_CSR_MCAUSE, '0), 0);
  endtask

  task automatic back_pressure();
    issue(build_req(op_xor, xorshift64(), xorshift64(), '0), 1 + int'(xorshift64() % 64'd10));
    issue(build_req(op_csrrw, xorshift64(), `EXEC_CSR_MSCRATCH, '0),
          1 + int'(xorshift64() % 64'd10));
    issue(build_req(op_csrrs, '0, `EXEC_CSR_MSCRATCH, '0), 0);
    issue(build_req(op_ecall, '0, '0, '0), 1 + int'(xorshift64() % 64'd10));
  endtask

  initial begin
    rng_state    = 64'd51;
    m_mtvec      = `EXEC_MTVEC_RESET;
    m_mscratch   = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    decoded_req  = 1'b0;
    decoded      = '0;
    executed_ack = 1'b0;
    check_reset_state();
    alu_sweep();
    control_flow();
    csr_access();
    ecall_trap();
    back_pressure();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== riscv_exec.f ====
+incdir+logic
logic/exec_pkg.sv
logic/exe_unit.sv
logic/exception_unit.sv
logic/csr_file.sv
logic/exe_stage.sv
logic/exec_top.sv
testbench/tb_clock_gen.sv
testbench/tb_exec_top.sv

// ==== Bender.yml ====
package:
  name: riscv_exec

sources:
  - include_dirs:
      - logic
    files:
      - logic/exec_pkg.sv
      - logic/exe_unit.sv
      - logic/exception_unit.sv
      - logic/csr_file.sv
      - logic/exe_stage.sv
      - logic/exec_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_exec_top.sv
